/* hdl/ccuPkg.sv */
// Sizes are fixed constants; CNT_W must be wide enough to hold ISA_DEPTH itself
`default_nettype none

package ccuPkg;

    // ========================================================
    // Widths and sizes
    // ========================================================
    localparam int ISA_WORD_W = 64;
    localparam int ISA_DEPTH  = 16;
    localparam int PTR_W      = $clog2(ISA_DEPTH);
    localparam int CNT_W      = 5;                 // Counts 0 .. ISA_DEPTH
    localparam int IDX_W      = 16;
    localparam int CHN_W      = 12;
    localparam int MAP_W      = 6;
    localparam int SCALE_W    = 20;
    localparam int ACT_W      = 8;
    localparam int LAYER_W    = 8;

    // Free-slot count of an empty buffer
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ISA_DEPTH);

    typedef enum logic [2:0] {
        OP_NET  = 3'd0,
        OP_CONV = 3'd1,
        OP_POOL = 3'd2
    } opcodeE;

    // ========================================================
    // Instruction word views, LSB field listed last
    // ========================================================
    typedef struct packed {
        logic [ISA_WORD_W-LAYER_W-4:0]     reserved;
        logic [LAYER_W-1:0]                layerCount;
        opcodeE                            opcode;
    } netWordT;

    // First word of a convolution
    typedef struct packed {
        logic [ISA_WORD_W-IDX_W-2*CHN_W-6:0] reserved;  // Opcode and mode take 5 bits
        logic [1:0]                          mode;
        logic [CHN_W-1:0]                    cho;
        logic [CHN_W-1:0]                    chi;
        logic [IDX_W-1:0]                    nip;
        opcodeE                              opcode;
    } convHeadT;

    // Second word of a convolution, no opcode
    typedef struct packed {
        logic [ISA_WORD_W-SCALE_W-2*ACT_W-1:0] reserved;
        logic [ACT_W-1:0]                      zp;
        logic [ACT_W-1:0]                      shift;
        logic [SCALE_W-1:0]                    scale;
    } convTailT;

    typedef struct packed {
        logic [ISA_WORD_W-MAP_W-IDX_W-CHN_W-4:0] reserved;
        logic [CHN_W-1:0]                        chi;
        logic [IDX_W-1:0]                        nip;
        logic [MAP_W-1:0]                        k;
        opcodeE                                  opcode;
    } poolWordT;

    // One buffer word, read as whichever view its position calls for
    typedef union packed {
        netWordT  net;
        convHeadT convHead;
        convTailT convTail;
        poolWordT pool;
    } isaWordU;

    // ========================================================
    // Engine configuration records
    // ========================================================
    typedef struct packed {
        logic [IDX_W-1:0]   nip;
        logic [CHN_W-1:0]   chi;
        logic [CHN_W-1:0]   cho;
        logic [1:0]         mode;
        logic [SCALE_W-1:0] scale;
        logic [ACT_W-1:0]   shift;
        logic [ACT_W-1:0]   zp;
    } convCfgT;

    typedef struct packed {
        logic [MAP_W-1:0] k;
        logic [IDX_W-1:0] nip;
        logic [CHN_W-1:0] chi;
    } poolCfgT;

    // Decoded instruction, fields foreign to op are zero
    typedef struct packed {
        opcodeE             op;
        logic [LAYER_W-1:0] layerCount;
        convCfgT            conv;
        poolCfgT            pool;
    } decInstrT;

endpackage

`default_nettype wire

/* hdl/isaBuffer.sv */
// Holds ISA_DEPTH words in total including the output register; new words show after one cycle
`default_nettype none

module isaBuffer (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // Host write side
    input  wire ccuPkg::isaWordU         isaWord,
    input  wire logic                    isaValid,
    output logic                         isaReady,
    output logic [ccuPkg::CNT_W-1:0]     freeSlots,
    // Decoder read side
    output ccuPkg::isaWordU              bufWord,
    output logic                         bufValid,
    input  wire logic                    bufReady
);

    ccuPkg::isaWordU            mem [ccuPkg::ISA_DEPTH];
    logic [ccuPkg::PTR_W-1:0]   wrPtr;
    logic [ccuPkg::PTR_W-1:0]   rdPtr;
    logic [ccuPkg::CNT_W-1:0]   memCount;   // Words in memory only
    logic [ccuPkg::CNT_W-1:0]   stored;     // Memory plus output register
    logic                       wrEn;
    logic                       loadOut;

    // ========================================================
    // Occupancy and handshakes
    // ========================================================
    assign stored    = memCount + {{(ccuPkg::CNT_W-1){1'b0}}, bufValid};
    assign isaReady  = (stored != ccuPkg::FULL_CNT);
    assign freeSlots = ccuPkg::FULL_CNT - stored;

    assign wrEn    = isaValid && isaReady;
    // Refill output register when empty or being drained
    assign loadOut = (memCount != '0) && (!bufValid || bufReady);

    // ========================================================
    // Storage
    // ========================================================
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= isaWord;
        end
    end

    always_ff @(posedge clk) begin
        if (loadOut) begin
            bufWord <= mem[rdPtr];   // Show-ahead word
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            memCount <= '0;
            bufValid <= 1'b0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (loadOut) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({wrEn, loadOut})
                2'b10:   memCount <= memCount + 1'b1;
                2'b01:   memCount <= memCount - 1'b1;
                default: memCount <= memCount;
            endcase
            if (loadOut) begin
                bufValid <= 1'b1;
            end else if (bufReady) begin
                bufValid <= 1'b0;    // Drained with nothing behind it
            end
        end
    end

    // ========================================================
    // Checks
    // ========================================================
    // A write never lands on a slot that still holds an unread word
    assert property (@(posedge clk) disable iff (!rst_n)
        wrEn |-> !((wrPtr == rdPtr) && (memCount != '0)))
        else $error("isaBuffer: word written while full");

endmodule

`default_nettype wire

/* hdl/isaDecoder.sv */
// Words with an unknown opcode in first position are dropped; a conv needs exactly one tail word
`default_nettype none

module isaDecoder (
    input  wire logic                clk,
    input  wire logic                rst_n,
    // From buffer
    input  wire ccuPkg::isaWordU     bufWord,
    input  wire logic                bufValid,
    output logic                     bufReady,
    // To sequencer
    output ccuPkg::decInstrT         dec,
    output logic                     decValid,
    input  wire logic                decReady
);

    logic               waitTail;    // Conv head seen, tail pending
    ccuPkg::convHeadT   headReg;
    ccuPkg::opcodeE     firstOp;
    ccuPkg::decInstrT   decNext;
    logic               bufHs;
    logic               instrDone;

    // ========================================================
    // Word acceptance
    // ========================================================
    // No new words while a record waits for the sequencer
    assign bufReady  = !decValid;
    assign bufHs     = bufValid && bufReady;
    assign firstOp   = bufWord.net.opcode;   // Opcode sits in the same bits in every view
    assign instrDone = bufHs && (waitTail || firstOp == ccuPkg::OP_NET
                                          || firstOp == ccuPkg::OP_POOL);

    // ========================================================
    // Record assembly
    // ========================================================
    always_comb begin
        decNext = '0;
        if (waitTail) begin
            decNext.op         = ccuPkg::OP_CONV;
            decNext.conv.nip   = headReg.nip;
            decNext.conv.chi   = headReg.chi;
            decNext.conv.cho   = headReg.cho;
            decNext.conv.mode  = headReg.mode;
            decNext.conv.scale = bufWord.convTail.scale;
            decNext.conv.shift = bufWord.convTail.shift;
            decNext.conv.zp    = bufWord.convTail.zp;
        end else begin
            decNext.op = firstOp;
            case (firstOp)
                ccuPkg::OP_NET: begin
                    decNext.layerCount = bufWord.net.layerCount;
                end
                ccuPkg::OP_POOL: begin
                    decNext.pool.k   = bufWord.pool.k;
                    decNext.pool.nip = bufWord.pool.nip;
                    decNext.pool.chi = bufWord.pool.chi;
                end
                default: ;   // Conv head goes to headReg
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bufHs && !waitTail && firstOp == ccuPkg::OP_CONV) begin
            headReg <= bufWord.convHead;
        end
        if (instrDone) begin
            dec <= decNext;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waitTail <= 1'b0;
            decValid <= 1'b0;
        end else begin
            if (bufHs && !waitTail && firstOp == ccuPkg::OP_CONV) begin
                waitTail <= 1'b1;
            end else if (bufHs && waitTail) begin
                waitTail <= 1'b0;
            end
            if (instrDone) begin
                decValid <= 1'b1;
            end else if (decReady) begin
                decValid <= 1'b0;    // Handshake done
            end
        end
    end

    // ========================================================
    // Checks
    // ========================================================
    // Host stream must start each instruction with a known opcode
    assert property (@(posedge clk) disable iff (!rst_n)
        (bufHs && !waitTail) |->
            (firstOp inside {ccuPkg::OP_NET, ccuPkg::OP_CONV, ccuPkg::OP_POOL}))
        else $error("isaDecoder: illegal opcode %0d in first word", firstOp);

endmodule

`default_nettype wire

/* hdl/layerSequencer.sv */
// One network per start pulse; expects one NET header followed by layerCount conv/pool records
`default_nettype none

module layerSequencer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    // From decoder
    input  wire ccuPkg::decInstrT    dec,
    input  wire logic                decValid,
    output logic                     decReady,
    // Convolution engine
    output ccuPkg::convCfgT          convCfg,
    output logic                     convCfgValid,
    input  wire logic                convCfgReady,
    // Pooling engine
    output ccuPkg::poolCfgT          poolCfg,
    output logic                     poolCfgValid,
    input  wire logic                poolCfgReady,
    output logic                     netDone,
    output logic                     engineRst
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEAD,
        S_LAYER,
        S_DONE
    } stateE;

    stateE                        state;
    stateE                        stateNext;
    logic [ccuPkg::LAYER_W-1:0]   layerCount;
    logic [ccuPkg::LAYER_W-1:0]   issued;       // Layer records taken so far
    logic                         decHs;
    logic                         layerTake;
    logic                         allIssued;
    logic                         cfgPending;   // Some valid still high after this edge

    // ========================================================
    // Status
    // ========================================================
    assign allIssued  = (issued == layerCount);
    assign cfgPending = (convCfgValid && !convCfgReady) || (poolCfgValid && !poolCfgReady);

    assign decReady  = (state == S_HEAD)
                    || (state == S_LAYER && !convCfgValid && !poolCfgValid && !allIssued);
    assign decHs     = decValid && decReady;
    assign layerTake = decHs && (state == S_LAYER);

    assign netDone   = (state == S_DONE);
    assign engineRst = (state == S_IDLE);

    // ========================================================
    // FSM
    // ========================================================
    always_comb begin
        stateNext = state;
        case (state)
            S_IDLE:  if (start) stateNext = S_HEAD;
            S_HEAD:  if (decHs) stateNext = (dec.layerCount == '0) ? S_DONE : S_LAYER;
            S_LAYER: if (allIssued && !cfgPending) stateNext = S_DONE;
            S_DONE:  stateNext = S_IDLE;
            default: stateNext = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            layerCount   <= '0;
            issued       <= '0;
            convCfgValid <= 1'b0;
            poolCfgValid <= 1'b0;
        end else begin
            state <= stateNext;
            if (decHs && state == S_HEAD) begin
                layerCount <= dec.layerCount;
                issued     <= '0;
            end else if (layerTake) begin
                issued <= issued + 1'b1;
            end
            if (convCfgValid && convCfgReady) begin
                convCfgValid <= 1'b0;
            end else if (layerTake && dec.op == ccuPkg::OP_CONV) begin
                convCfgValid <= 1'b1;
            end
            if (poolCfgValid && poolCfgReady) begin
                poolCfgValid <= 1'b0;
            end else if (layerTake && dec.op == ccuPkg::OP_POOL) begin
                poolCfgValid <= 1'b1;
            end
        end
    end

    // Engine config registers
    always_ff @(posedge clk) begin
        if (layerTake && dec.op == ccuPkg::OP_CONV) convCfg <= dec.conv;
        if (layerTake && dec.op == ccuPkg::OP_POOL) poolCfg <= dec.pool;
    end

    // ========================================================
    // Checks
    // ========================================================
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_HEAD && decValid) |-> (dec.op == ccuPkg::OP_NET))
        else $error("layerSequencer: header expected, got opcode %0d", dec.op);

    // Next network's header may already wait once all layers are taken
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_LAYER && decValid && !allIssued) |-> (dec.op != ccuPkg::OP_NET))
        else $error("layerSequencer: network header inside layer list");

    // Held config must not move before the engine takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (convCfgValid && !convCfgReady) |=> (convCfgValid && $stable(convCfg)))
        else $error("layerSequencer: conv config changed while pending");

    assert property (@(posedge clk) disable iff (!rst_n)
        (poolCfgValid && !poolCfgReady) |=> (poolCfgValid && $stable(poolCfg)))
        else $error("layerSequencer: pool config changed while pending");

endmodule

`default_nettype wire

/* hdl/ccuTop.sv */
// Instructions must be written in network order; engines stay in reset while no network runs
`default_nettype none

module ccuTop (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start,
    // Host instruction port
    input  wire ccuPkg::isaWordU         isaWord,
    input  wire logic                    isaValid,
    output logic                         isaReady,
    output logic [ccuPkg::CNT_W-1:0]     freeSlots,
    // Engine configuration ports
    output ccuPkg::convCfgT              convCfg,
    output logic                         convCfgValid,
    input  wire logic                    convCfgReady,
    output ccuPkg::poolCfgT              poolCfg,
    output logic                         poolCfgValid,
    input  wire logic                    poolCfgReady,
    output logic                         netDone,
    output logic                         engineRst
);

    // ========================================================
    // Internal links
    // ========================================================
    ccuPkg::isaWordU    bufWord;
    logic               bufValid;
    logic               bufReady;
    ccuPkg::decInstrT   dec;
    logic               decValid;
    logic               decReady;

    isaBuffer i_isaBuffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .isaWord   (isaWord),
        .isaValid  (isaValid),
        .isaReady  (isaReady),
        .freeSlots (freeSlots),
        .bufWord   (bufWord),
        .bufValid  (bufValid),
        .bufReady  (bufReady)
    );

    isaDecoder i_isaDecoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .bufWord  (bufWord),
        .bufValid (bufValid),
        .bufReady (bufReady),
        .dec      (dec),
        .decValid (decValid),
        .decReady (decReady)
    );

    layerSequencer i_layerSequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .dec          (dec),
        .decValid     (decValid),
        .decReady     (decReady),
        .convCfg      (convCfg),
        .convCfgValid (convCfgValid),
        .convCfgReady (convCfgReady),
        .poolCfg      (poolCfg),
        .poolCfgValid (poolCfgValid),
        .poolCfgReady (poolCfgReady),
        .netDone      (netDone),
        .engineRst    (engineRst)
    );

endmodule

`default_nettype wire

/* test/ccuTb.sv */
// Runs one network at a time from random stimulus; the buffer count is checked only while idle
`default_nettype none

module ccuTb;

    timeunit 1ns;
    timeprecision 1ps;

    // One expected engine record, in issue order
    typedef struct packed {
        logic            isConv;
        ccuPkg::convCfgT conv;
        ccuPkg::poolCfgT pool;
    } expCfgT;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        start;
    ccuPkg::isaWordU             isaWord;
    logic                        isaValid;
    logic                        isaReady;
    logic [ccuPkg::CNT_W-1:0]    freeSlots;
    ccuPkg::convCfgT             convCfg;
    logic                        convCfgValid;
    logic                        convCfgReady;
    ccuPkg::poolCfgT             poolCfg;
    logic                        poolCfgValid;
    logic                        poolCfgReady;
    logic                        netDone;
    logic                        engineRst;

    logic [31:0]                 lfsr = 32'h1dbf;       // Stimulus stream
    logic [31:0]                 readyLfsr = 32'h1dbf;  // Engine ready stream
    ccuPkg::isaWordU             netWords[$];
    expCfgT                      expQ[$];
    int                          valueErrors = 0;
    int                          protoErrors = 0;
    int                          wordsWritten = 0;
    int                          doneCount = 0;
    int                          cycles = 0;

    always #2 clk = ~clk;

    ccuTop i_dut (.*);

    // ========================================================
    // Random numbers and reference model
    // ========================================================
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = stepLfsr(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    // Engine record that the written words of one layer must produce
    function automatic expCfgT refConfig(input ccuPkg::isaWordU first,
                                         input ccuPkg::isaWordU second);
        expCfgT e;
        e = '0;
        if (first.convHead.opcode == ccuPkg::OP_CONV) begin
            e.isConv     = 1'b1;
            e.conv.nip   = first.convHead.nip;
            e.conv.chi   = first.convHead.chi;
            e.conv.cho   = first.convHead.cho;
            e.conv.mode  = first.convHead.mode;
            e.conv.scale = second.convTail.scale;
            e.conv.shift = second.convTail.shift;
            e.conv.zp    = second.convTail.zp;
        end else begin
            e.pool.k   = first.pool.k;
            e.pool.nip = first.pool.nip;
            e.pool.chi = first.pool.chi;
        end
        return e;
    endfunction

    // ========================================================
    // Checks
    // ========================================================
    task automatic checkConv(input string name, input ccuPkg::convCfgT exp,
                             input ccuPkg::convCfgT act);
        if (act !== exp) begin
            valueErrors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkPool(input string name, input ccuPkg::poolCfgT exp,
                             input ccuPkg::poolCfgT act);
        if (act !== exp) begin
            valueErrors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input logic [ccuPkg::CNT_W-1:0] exp,
                              input logic [ccuPkg::CNT_W-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic protocolError(input string msg);
        protoErrors++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    // ========================================================
    // Stimulus
    // ========================================================
    // Fills netWords with one network and queues its expected records
    task automatic buildNetwork(input int layers, input logic allConv);
        ccuPkg::isaWordU head;
        ccuPkg::isaWordU tail;
        logic [31:0]     r;
        netWords.delete();
        head = '0;
        head.net.opcode     = ccuPkg::OP_NET;
        head.net.layerCount = layers[ccuPkg::LAYER_W-1:0];
        netWords.push_back(head);
        for (int i = 0; i < layers; i++) begin
            head = '0;
            tail = '0;
            if (allConv || randBits(1) == 0) begin
                head.convHead.opcode = ccuPkg::OP_CONV;
                r = randBits(ccuPkg::IDX_W);
                head.convHead.nip = r[ccuPkg::IDX_W-1:0];
                r = randBits(ccuPkg::CHN_W);
                head.convHead.chi = r[ccuPkg::CHN_W-1:0];
                r = randBits(ccuPkg::CHN_W);
                head.convHead.cho = r[ccuPkg::CHN_W-1:0];
                r = randBits(2);
                head.convHead.mode = r[1:0];
                r = randBits(ccuPkg::SCALE_W);
                tail.convTail.scale = r[ccuPkg::SCALE_W-1:0];
                r = randBits(2 * ccuPkg::ACT_W);
                tail.convTail.shift = r[ccuPkg::ACT_W-1:0];
                tail.convTail.zp    = r[2*ccuPkg::ACT_W-1:ccuPkg::ACT_W];
                netWords.push_back(head);
                netWords.push_back(tail);
            end else begin
                head.pool.opcode = ccuPkg::OP_POOL;
                r = randBits(ccuPkg::MAP_W);
                head.pool.k = r[ccuPkg::MAP_W-1:0];
                r = randBits(ccuPkg::IDX_W);
                head.pool.nip = r[ccuPkg::IDX_W-1:0];
                r = randBits(ccuPkg::CHN_W);
                head.pool.chi = r[ccuPkg::CHN_W-1:0];
                netWords.push_back(head);
            end
            expQ.push_back(refConfig(head, tail));
        end
    endtask

    // Called at posedge+1, returns at posedge+1
    task automatic sendWord(input ccuPkg::isaWordU w);
        logic [31:0] gap;
        isaWord  = w;
        isaValid = 1'b1;
        @(negedge clk);
        while (!isaReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        isaValid = 1'b0;
        wordsWritten++;
        gap = randBits(2);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runNetwork(input int layers, input logic allConv, input logic fullCheck);
        int                       doneBefore;
        int                       freeNow;
        logic [ccuPkg::CNT_W-1:0] expFree;
        buildNetwork(layers, allConv);
        foreach (netWords[i]) begin
            sendWord(netWords[i]);
        end
        repeat (5) begin
            @(posedge clk);
        end
        @(negedge clk);
        // Header already waits in the decoder, the rest stays in the buffer
        freeNow = ccuPkg::ISA_DEPTH - (netWords.size() - 1);
        expFree = freeNow[ccuPkg::CNT_W-1:0];
        checkCount("free slots before start", expFree, freeSlots);
        if (fullCheck && isaReady) begin
            protocolError("buffer is full but isaReady is still high");
        end
        @(posedge clk);
        #1;
        doneBefore = doneCount;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (doneCount == doneBefore) begin
            @(posedge clk);
        end
        repeat (3) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (doneCount != doneBefore + 1) begin
            protocolError($sformatf("netDone pulsed %0d times for one network",
                                    doneCount - doneBefore));
        end
        if (expQ.size() != 0) begin
            protocolError($sformatf("%0d configurations never issued", expQ.size()));
            expQ.delete();
        end
        checkCount("free slots after network", ccuPkg::FULL_CNT, freeSlots);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int          layers;
        logic [31:0] r;
        rst_n    = 1'b0;
        start    = 1'b0;
        isaValid = 1'b0;
        isaWord  = '0;
        repeat (4) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        checkCount("free slots after reset", ccuPkg::FULL_CNT, freeSlots);
        if (!isaReady || convCfgValid || poolCfgValid || netDone || !engineRst) begin
            protocolError("outputs not in their reset state");
        end
        @(posedge clk);
        #1;
        runNetwork(8, 1'b1, 1'b1);    // 17 words, buffer ends up full
        runNetwork(0, 1'b0, 1'b0);
        for (int n = 0; n < 14; n++) begin
            r = randBits(3);
            layers = r % 7;
            runNetwork(layers, 1'b0, 1'b0);
        end
        $display("Errors: %0d value, %0d protocol", valueErrors, protoErrors);
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ========================================================
    // Engine ready, monitor and timeout
    // ========================================================
    initial begin
        convCfgReady = 1'b0;
        poolCfgReady = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            readyLfsr    = stepLfsr(readyLfsr);
            convCfgReady = readyLfsr[0];
            readyLfsr    = stepLfsr(readyLfsr);
            poolCfgReady = readyLfsr[0];
        end
    end

    // Samples mid-cycle, a handshake here completes on the next edge
    initial begin
        logic            convHeld;
        logic            poolHeld;
        logic            expRst;
        ccuPkg::convCfgT convLast;
        ccuPkg::poolCfgT poolLast;
        expCfgT          head;
        convHeld = 1'b0;
        poolHeld = 1'b0;
        expRst   = 1'b1;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (convHeld && (!convCfgValid || convCfg !== convLast)) begin
                    protocolError("conv config dropped or changed before ready");
                end
                if (poolHeld && (!poolCfgValid || poolCfg !== poolLast)) begin
                    protocolError("pool config dropped or changed before ready");
                end
                if (convCfgValid && convCfgReady) begin
                    if (expQ.size() == 0 || !expQ[0].isConv) begin
                        protocolError("conv config issued out of order");
                    end else begin
                        head = expQ.pop_front();
                        checkConv("conv decode", head.conv, convCfg);
                    end
                end
                if (poolCfgValid && poolCfgReady) begin
                    if (expQ.size() == 0 || expQ[0].isConv) begin
                        protocolError("pool config issued out of order");
                    end else begin
                        head = expQ.pop_front();
                        checkPool("pool decode", head.pool, poolCfg);
                    end
                end
                convHeld = convCfgValid && !convCfgReady;
                poolHeld = poolCfgValid && !poolCfgReady;
                convLast = convCfg;
                poolLast = poolCfg;
                if (engineRst !== expRst) begin
                    protocolError($sformatf("engineRst is %b, expected %b", engineRst, expRst));
                end
                if (netDone) begin
                    doneCount++;
                    if (expQ.size() != 0) begin
                        protocolError("netDone with configurations still outstanding");
                    end
                    if (expRst) begin
                        protocolError("netDone while no network runs");
                    end
                    expRst = 1'b1;
                end else if (start && expRst) begin
                    expRst = 1'b0;             // Sequencer leaves idle on next edge
                end
            end
        end
    end

    // Limit grows with every word sent
    initial begin
        while (cycles <= 1000 + 50 * wordsWritten) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/ccuPkg.sv
hdl/isaBuffer.sv
hdl/isaDecoder.sv
hdl/layerSequencer.sv
hdl/ccuTop.sv
test/ccuTb.sv

/* run.sh */
#!/bin/sh
# Builds the simulation with Verilator and runs it; passes only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module ccuTb -o ccuSim &&
./obj_dir/ccuSim | tee /dev/stderr | grep -qx "TEST PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
